// File: all.f
+incdir+source
source/params_pkg.sv
source/mem_wb_reg.sv
source/wb_stage.sv
source/regfile.sv
source/csr_file.sv
source/wb_top.sv
verification/wb_clock_gen.sv
verification/wb_properties.sv
verification/wb_tb.sv

// File: Makefile
# Verilator flow for the writeback testbench
VERILATOR ?= verilator
TOP       ?= wb_tb
RTL_TOP   ?= wb_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert
PASS_MSG  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/wb_tb.sv
`include "core_defs.svh"

module wb_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import params_pkg::*;

  // sweep 32, results 40, x0 8, traps 8, csr 20, stall/flush 16, drain 4
  localparam int N_ITEMS    = 128;
  localparam int TIMEOUT_NS = (N_ITEMS + 3 + 40) * 20;

  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       rd_wdata;
  } wb_expect_t;

  logic                   clk;
  logic                   reset;
  mem_wb_t                mem_stage;
  logic                   stall;
  logic                   flush;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`CSR_ADDR_W-1:0] csr_raddr;
  logic [`XLEN-1:0]       rs1_rdata;
  logic [`XLEN-1:0]       rs2_rdata;
  logic [`XLEN-1:0]       csr_rdata;
  logic [`XLEN-1:0]       trap_pc;
  logic                   trap_valid;
  rvfi_t                  rvfi;

  integer seed = 32'hd1c8;
  int     n_checks = 0;
  int     n_errors = 0;

  // model of the pipeline register and architectural state
  mem_wb_t                pipe_m;
  logic [`XLEN-1:0]       regs_m [0:`NUM_REGS-1];
  logic [`XLEN-1:0]       mscratch_m;
  logic [`XLEN-1:0]       mtvec_m;
  logic [`XLEN-1:0]       mepc_m;
  logic [`XLEN-1:0]       mcause_m;
  logic [`REG_ADDR_W-1:0] rd_hist [0:1];

  wb_clock_gen i_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  wb_top i_dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .mem_stage_i  (mem_stage),
    .stall_i      (stall),
    .flush_i      (flush),
    .rs1_addr_i   (rs1_addr),
    .rs2_addr_i   (rs2_addr),
    .csr_raddr_i  (csr_raddr),
    .rs1_rdata_o  (rs1_rdata),
    .rs2_rdata_o  (rs2_rdata),
    .csr_rdata_o  (csr_rdata),
    .trap_pc_o    (trap_pc),
    .trap_valid_o (trap_valid),
    .rvfi_o       (rvfi)
  );

  bind wb_stage wb_properties i_wb_properties (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .wb_pipeline_q_i (wb_pipeline_q_i),
    .wb_rd_addr_i    (wb_rd_addr_o),
    .wb_rd_wdata_i   (wb_rd_wdata_o),
    .wb_csr_addr_i   (wb_csr_addr_o),
    .wb_trap_valid_i (wb_trap_valid_o),
    .rvfi_i          (rvfi_o)
  );

  function automatic wb_expect_t expected_writeback(input mem_wb_t rec);
    wb_expect_t       e;
    logic [`XLEN-1:0] sel;
    case (rec.result_sel)
      RESULT_SEL_ALU_RESULT:      sel = rec.alu_csr_result;
      RESULT_SEL_MEM_DATA:        sel = rec.load_rdata;
      RESULT_SEL_NEXT_INSTR_ADDR: sel = rec.pc_plus_4;
      default:                    sel = rec.csr_rdata;
    endcase
    e.rd_addr  = rec.carried_trap.valid ? '0 : rec.rd_addr;
    e.rd_wdata = (e.rd_addr == '0) ? '0 : sel;
    return e;
  endfunction

  function automatic logic csr_is_impl(input logic [`CSR_ADDR_W-1:0] addr);
    return (addr == `CSR_MSCRATCH) || (addr == `CSR_MTVEC) ||
           (addr == `CSR_MEPC) || (addr == `CSR_MCAUSE);
  endfunction

  function automatic logic [`XLEN-1:0] csr_model_read(input logic [`CSR_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] v;
    case (addr)
      `CSR_MSCRATCH: v = mscratch_m;
      `CSR_MTVEC:    v = mtvec_m;
      `CSR_MEPC:     v = mepc_m;
      `CSR_MCAUSE:   v = mcause_m;
      default:       v = '0;
    endcase
    return v;
  endfunction

  // four implemented csrs and one address outside the set
  function automatic logic [`CSR_ADDR_W-1:0] pick_csr(input int idx);
    logic [`CSR_ADDR_W-1:0] a;
    case (idx % 5)
      0:       a = `CSR_MSCRATCH;
      1:       a = `CSR_MTVEC;
      2:       a = `CSR_MEPC;
      3:       a = `CSR_MCAUSE;
      default: a = 12'h7c3;
    endcase
    return a;
  endfunction

  task automatic check_word(input string name, input logic [`XLEN-1:0] expected,
                            input logic [`XLEN-1:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("MISMATCH %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_reg_addr(input string name, input logic [`REG_ADDR_W-1:0] expected,
                                input logic [`REG_ADDR_W-1:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("MISMATCH %0t %s expected %0d actual %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_trap(input string name, input trap_info_t expected,
                            input trap_info_t actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("MISMATCH %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic make_record(output mem_wb_t rec);
    logic [`XLEN-1:0] r;
    rec                = '0;
    rec.valid          = 1'b1;
    rec.pc             = $random(seed);
    rec.next_pc        = $random(seed);
    rec.insn           = $random(seed);
    rec.rs1_rdata      = $random(seed);
    rec.rs2_rdata      = $random(seed);
    rec.alu_csr_result = $random(seed);
    rec.load_rdata     = $random(seed);
    rec.csr_rdata      = $random(seed);
    rec.csr_wdata      = $random(seed);
    rec.store_wdata    = $random(seed);
    rec.pc_plus_4      = rec.pc + 32'd4;
    r                  = $random(seed);
    rec.rs1_addr       = r[4:0];
    rec.rs2_addr       = r[9:5];
    rec.rd_addr        = r[14:10];
    rec.result_sel     = result_sel_t'(r[16:15]);
    rec.load_rmask     = r[20:17];
    rec.store_wmask    = r[24:21];
    rec.intr           = r[25];
  endtask

  task automatic drive(input mem_wb_t rec, input logic stall_v, input logic flush_v,
                       input logic [`REG_ADDR_W-1:0] rs1, input logic [`REG_ADDR_W-1:0] rs2,
                       input logic [`CSR_ADDR_W-1:0] craddr);
    @(posedge clk);
    mem_stage <= rec;
    stall     <= stall_v;
    flush     <= flush_v;
    rs1_addr  <= rs1;
    rs2_addr  <= rs2;
    csr_raddr <= craddr;
  endtask

  // read ports look at the rd written two items back
  task automatic send(input mem_wb_t rec, input int idx);
    drive(rec, 1'b0, 1'b0, rd_hist[1], rd_hist[1], pick_csr(idx));
    rd_hist[1] = rd_hist[0];
    rd_hist[0] = rec.rd_addr;
  endtask

  always @(posedge clk) begin : model
    wb_expect_t w;
    if (reset) begin
      pipe_m     = '0;
      mscratch_m = '0;
      mtvec_m    = '0;
      mepc_m     = '0;
      mcause_m   = '0;
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_m[i] = '0;
      end
    end else begin
      w = expected_writeback(pipe_m);
      if (w.rd_addr != '0) begin
        regs_m[w.rd_addr] = w.rd_wdata;
      end
      if (pipe_m.carried_trap.valid) begin
        mepc_m   = pipe_m.carried_trap.pc;
        mcause_m = `XLEN'(pipe_m.carried_trap.cause);
      end else begin
        case (pipe_m.csr_addr)
          `CSR_MSCRATCH: mscratch_m = pipe_m.csr_wdata;
          `CSR_MTVEC:    mtvec_m    = pipe_m.csr_wdata;
          `CSR_MEPC:     mepc_m     = pipe_m.csr_wdata;
          `CSR_MCAUSE:   mcause_m   = pipe_m.csr_wdata;
          default:       ;
        endcase
      end
      if (flush) begin
        pipe_m = '0;
      end else if (!stall) begin
        pipe_m = mem_stage;
      end
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clk) begin : compare
    wb_expect_t             exp_wb;
    trap_info_t             exp_trap;
    logic [`CSR_ADDR_W-1:0] exp_csr_addr;
    logic [`XLEN-1:0]       exp_mask;
    if (!reset) begin
      exp_wb = expected_writeback(pipe_m);
      if (pipe_m.carried_trap.valid) begin
        exp_trap     = pipe_m.carried_trap;
        exp_csr_addr = '0;
      end else begin
        exp_trap     = '0;
        exp_csr_addr = pipe_m.csr_addr;
      end
      exp_mask = csr_is_impl(exp_csr_addr) ? '1 : '0;
      check_word("rvfi_o.valid", `XLEN'(pipe_m.valid), `XLEN'(rvfi.valid));
      check_word("rvfi_o.pc_rdata", pipe_m.pc, rvfi.pc_rdata);
      check_reg_addr("rvfi_o.rd_addr", exp_wb.rd_addr, rvfi.rd_addr);
      check_word("rvfi_o.rd_wdata", exp_wb.rd_wdata, rvfi.rd_wdata);
      check_word("rvfi_o.csr_addr", `XLEN'(exp_csr_addr), `XLEN'(rvfi.csr_addr));
      check_word("rvfi_o.csr_rmask", exp_mask, rvfi.csr_rmask);
      check_word("rvfi_o.csr_wmask", exp_mask, rvfi.csr_wmask);
      check_trap("rvfi_o.trap", exp_trap, rvfi.trap);
      check_word("rvfi_o.intr", `XLEN'(pipe_m.intr), `XLEN'(rvfi.intr));
      check_word("rvfi_o.insn", pipe_m.insn, rvfi.insn);
      check_word("rvfi_o.pc_wdata", pipe_m.next_pc, rvfi.pc_wdata);
      check_reg_addr("rvfi_o.rs1_addr", pipe_m.rs1_addr, rvfi.rs1_addr);
      check_reg_addr("rvfi_o.rs2_addr", pipe_m.rs2_addr, rvfi.rs2_addr);
      check_word("rvfi_o.rs1_rdata", pipe_m.rs1_rdata, rvfi.rs1_rdata);
      check_word("rvfi_o.rs2_rdata", pipe_m.rs2_rdata, rvfi.rs2_rdata);
      check_word("rvfi_o.csr_rdata", pipe_m.csr_rdata, rvfi.csr_rdata);
      check_word("rvfi_o.csr_wdata", pipe_m.csr_wdata, rvfi.csr_wdata);
      // loads and stores use the alu result as address
      check_word("rvfi_o.mem_addr", pipe_m.alu_csr_result, rvfi.mem_addr);
      check_word("rvfi_o.mem_rmask", `XLEN'(pipe_m.load_rmask), `XLEN'(rvfi.mem_rmask));
      check_word("rvfi_o.mem_rdata", pipe_m.load_rdata, rvfi.mem_rdata);
      check_word("rvfi_o.mem_wmask", `XLEN'(pipe_m.store_wmask), `XLEN'(rvfi.mem_wmask));
      check_word("rvfi_o.mem_wdata", pipe_m.store_wdata, rvfi.mem_wdata);
      check_word("trap_valid_o", `XLEN'(exp_trap.valid), `XLEN'(trap_valid));
      check_word("rs1_rdata_o", regs_m[rs1_addr], rs1_rdata);
      check_word("rs2_rdata_o", regs_m[rs2_addr], rs2_rdata);
      check_word("csr_rdata_o", csr_model_read(csr_raddr), csr_rdata);
      check_word("trap_pc_o", mtvec_m, trap_pc);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired at %0t before the stimulus finished", $time);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    mem_wb_t          rec;
    logic [`XLEN-1:0] r;
    int               assert_fails;
    mem_stage  = '0;
    stall      = 1'b0;
    flush      = 1'b0;
    rs1_addr   = '0;
    rs2_addr   = '0;
    csr_raddr  = '0;
    rd_hist[0] = '0;
    rd_hist[1] = '0;
    wait (!reset);

    // every register and csr reads zero after reset
    for (int i = 0; i < 32; i++) begin
      drive('0, 1'b0, 1'b0, i[4:0], 5'(31 - i), pick_csr(i));
    end

    for (int k = 0; k < 40; k++) begin
      make_record(rec);
      rec.result_sel = result_sel_t'(k[1:0]);
      if (rec.rd_addr == '0) begin
        rec.rd_addr = 5'd1;
      end
      send(rec, k);
    end

    for (int k = 0; k < 8; k++) begin
      make_record(rec);
      rec.rd_addr = '0;
      send(rec, k);
    end

    // trapped items aimed at real registers and csrs
    for (int k = 0; k < 8; k++) begin
      make_record(rec);
      r                      = $random(seed);
      rec.rd_addr            = 5'd1 + 5'(k);
      rec.csr_addr           = pick_csr(k);
      rec.carried_trap.valid = 1'b1;
      rec.carried_trap.cause = r[3:0];
      rec.carried_trap.pc    = rec.pc;
      send(rec, k + 2);
    end

    for (int k = 0; k < 20; k++) begin
      make_record(rec);
      rec.csr_addr = pick_csr(k);
      send(rec, k + 3);
    end

    // random stall and occasional flush
    for (int k = 0; k < 16; k++) begin
      make_record(rec);
      r = $random(seed);
      drive(rec, r[0], r[3:1] == 3'd0, r[8:4], r[13:9], pick_csr(k));
    end

    for (int k = 0; k < 4; k++) begin
      drive('0, 1'b0, 1'b0, 5'(k), 5'(k + 8), pick_csr(k));
    end
    // last falling edge compare has run by the next rising edge
    @(posedge clk);

    assert_fails = i_dut.i_wb_stage.i_wb_properties.fail_count;
    $display("checks run %0d, errors %0d, assertion failures %0d",
             n_checks, n_errors, assert_fails);
    if (n_errors == 0 && assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verification/wb_properties.sv
`include "core_defs.svh"

module wb_properties (
  input logic                   clk_i,
  input logic                   reset_i,
  input params_pkg::mem_wb_t    wb_pipeline_q_i,
  input logic [`REG_ADDR_W-1:0] wb_rd_addr_i,
  input logic [`XLEN-1:0]       wb_rd_wdata_i,
  input logic [`CSR_ADDR_W-1:0] wb_csr_addr_i,
  input logic                   wb_trap_valid_i,
  input params_pkg::rvfi_t      rvfi_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // a trapped instruction retires no register or csr write
  trap_masks_writes: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_pipeline_q_i.carried_trap.valid |-> (wb_rd_addr_i == '0) && (wb_csr_addr_i == '0))
    else begin
      $error("trapped instruction still carries a write address");
      fail_count++;
    end

  // x0 never receives data
  x0_data_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_rd_addr_i == '0) |-> (wb_rd_wdata_i == '0))
    else begin
      $error("rd data is not zero while rd address is x0");
      fail_count++;
    end

  rvfi_trap_matches: assert property (@(posedge clk_i) disable iff (reset_i)
    rvfi_i.trap.valid == wb_trap_valid_i)
    else begin
      $error("rvfi trap valid disagrees with the trap valid output");
      fail_count++;
    end

endmodule

// File: verification/wb_clock_gen.sv
module wb_clock_gen (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // synchronous reset held over three rising edges
  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: source/wb_top.sv
`include "core_defs.svh"

module wb_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  params_pkg::mem_wb_t    mem_stage_i,
  input  logic                   stall_i,
  input  logic                   flush_i,
  input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [`CSR_ADDR_W-1:0] csr_raddr_i,
  output logic [`XLEN-1:0]       rs1_rdata_o,
  output logic [`XLEN-1:0]       rs2_rdata_o,
  output logic [`XLEN-1:0]       csr_rdata_o,
  output logic [`XLEN-1:0]       trap_pc_o,
  output logic                   trap_valid_o,
  output params_pkg::rvfi_t      rvfi_o
);
  import params_pkg::*;

  mem_wb_t                wb_pipeline_q;
  trap_info_t             wb_trap;
  logic [`REG_ADDR_W-1:0] wb_rd_addr;
  logic [`XLEN-1:0]       wb_rd_wdata;
  logic [`CSR_ADDR_W-1:0] wb_csr_addr;
  logic [`XLEN-1:0]       wb_csr_wdata;
  logic [`XLEN-1:0]       csr_rmask;
  logic [`XLEN-1:0]       csr_wmask;

  mem_wb_reg i_mem_wb_reg (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .stall_i         (stall_i),
    .flush_i         (flush_i),
    .mem_stage_i     (mem_stage_i),
    .wb_pipeline_q_o (wb_pipeline_q)
  );

  wb_stage i_wb_stage (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .wb_pipeline_q_i (wb_pipeline_q),
    .wb_csr_rmask_i  (csr_rmask),
    .wb_csr_wmask_i  (csr_wmask),
    .wb_csr_addr_o   (wb_csr_addr),
    .wb_csr_wdata_o  (wb_csr_wdata),
    .wb_rd_addr_o    (wb_rd_addr),
    .wb_rd_wdata_o   (wb_rd_wdata),
    .wb_trap_o       (wb_trap),
    .wb_trap_valid_o (trap_valid_o),
    .rvfi_o          (rvfi_o)
  );

  regfile i_regfile (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rd_addr_i   (wb_rd_addr),
    .rd_wdata_i  (wb_rd_wdata),
    .rs1_addr_i  (rs1_addr_i),
    .rs2_addr_i  (rs2_addr_i),
    .rs1_rdata_o (rs1_rdata_o),
    .rs2_rdata_o (rs2_rdata_o)
  );

  csr_file i_csr_file (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .csr_addr_i  (wb_csr_addr),
    .csr_wdata_i (wb_csr_wdata),
    .trap_i      (wb_trap),
    .csr_raddr_i (csr_raddr_i),
    .csr_rdata_o (csr_rdata_o),
    .csr_rmask_o (csr_rmask),
    .csr_wmask_o (csr_wmask),
    .trap_pc_o   (trap_pc_o)
  );

endmodule

// File: source/csr_file.sv
`include "core_defs.svh"

module csr_file (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // write port from writeback, zero address means idle
  input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`XLEN-1:0]       csr_wdata_i,
  input  params_pkg::trap_info_t trap_i,
  // read back port
  input  logic [`CSR_ADDR_W-1:0] csr_raddr_i,
  output logic [`XLEN-1:0]       csr_rdata_o,
  // access masks for the write port address
  output logic [`XLEN-1:0]       csr_rmask_o,
  output logic [`XLEN-1:0]       csr_wmask_o,
  // trap redirect target
  output logic [`XLEN-1:0]       trap_pc_o
);

  logic [`XLEN-1:0] mscratch_q;
  logic [`XLEN-1:0] mtvec_q;
  logic [`XLEN-1:0] mepc_q;
  logic [`XLEN-1:0] mcause_q;
  logic             wr_impl;

  function automatic logic is_impl(input logic [`CSR_ADDR_W-1:0] addr);
    logic hit;
    hit = (addr == `CSR_MSCRATCH) || (addr == `CSR_MTVEC) ||
          (addr == `CSR_MEPC) || (addr == `CSR_MCAUSE);
    return hit;
  endfunction

  assign wr_impl = is_impl(csr_addr_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mscratch_q <= '0;
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else if (trap_i.valid) begin
      // trap capture beats any csr write in the same cycle
      mepc_q   <= trap_i.pc;
      mcause_q <= {{(`XLEN-`CAUSE_W){1'b0}}, trap_i.cause};
    end else if (wr_impl) begin
      case (csr_addr_i)
        `CSR_MSCRATCH: mscratch_q <= csr_wdata_i;
        `CSR_MTVEC:    mtvec_q    <= csr_wdata_i;
        `CSR_MEPC:     mepc_q     <= csr_wdata_i;
        `CSR_MCAUSE:   mcause_q   <= csr_wdata_i;
        default:       mscratch_q <= mscratch_q;
      endcase
    end
  end

  // full access to every implemented csr, none elsewhere
  assign csr_rmask_o = wr_impl ? '1 : '0;
  assign csr_wmask_o = wr_impl ? '1 : '0;

  always_comb begin
    case (csr_raddr_i)
      `CSR_MSCRATCH: csr_rdata_o = mscratch_q;
      `CSR_MTVEC:    csr_rdata_o = mtvec_q;
      `CSR_MEPC:     csr_rdata_o = mepc_q;
      `CSR_MCAUSE:   csr_rdata_o = mcause_q;
      default:       csr_rdata_o = '0;
    endcase
  end

  // direct mode only, handler starts at mtvec
  assign trap_pc_o = mtvec_q;

endmodule

// File: source/regfile.sv
`include "core_defs.svh"

module regfile (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // write port from writeback
  input  logic [`REG_ADDR_W-1:0] rd_addr_i,
  input  logic [`XLEN-1:0]       rd_wdata_i,
  // decode side read ports
  input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
  output logic [`XLEN-1:0]       rs1_rdata_o,
  output logic [`XLEN-1:0]       rs2_rdata_o
);

  // x0 has no storage
  logic [`XLEN-1:0] regs_q [1:`NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (rd_addr_i != '0) begin
      regs_q[rd_addr_i] <= rd_wdata_i;
    end
  end

  // reads see the old value during a write, no bypass
  assign rs1_rdata_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_rdata_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

// File: source/wb_stage.sv
`include "core_defs.svh"

module wb_stage (
  // clock and reset only feed the formal wrapper bound to this stage
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  params_pkg::mem_wb_t    wb_pipeline_q_i,
  // masks of the csr being accessed
  input  logic [`XLEN-1:0]       wb_csr_rmask_i,
  input  logic [`XLEN-1:0]       wb_csr_wmask_i,
  // csr write port
  output logic [`CSR_ADDR_W-1:0] wb_csr_addr_o,
  output logic [`XLEN-1:0]       wb_csr_wdata_o,
  // regfile write port
  output logic [`REG_ADDR_W-1:0] wb_rd_addr_o,
  output logic [`XLEN-1:0]       wb_rd_wdata_o,
  // trap capture
  output params_pkg::trap_info_t wb_trap_o,
  output logic                   wb_trap_valid_o,
  output params_pkg::rvfi_t      rvfi_o
);
  import params_pkg::*;

  trap_info_t             trap_d;
  logic [`XLEN-1:0]       rd_wdata_sel;
  logic [`REG_ADDR_W-1:0] rd_addr_masked;
  logic [`XLEN-1:0]       rd_wdata_masked;
  logic [`CSR_ADDR_W-1:0] csr_addr_masked;
  logic                   trapped;

  assign trapped = wb_pipeline_q_i.carried_trap.valid;

  // trap info is all zero unless a trap is really carried
  assign trap_d = trapped ? wb_pipeline_q_i.carried_trap : '0;

  always_comb begin
    rd_wdata_sel = '0;
    case (wb_pipeline_q_i.result_sel)
      RESULT_SEL_ALU_RESULT:      rd_wdata_sel = wb_pipeline_q_i.alu_csr_result;
      RESULT_SEL_MEM_DATA:        rd_wdata_sel = wb_pipeline_q_i.load_rdata;
      RESULT_SEL_NEXT_INSTR_ADDR: rd_wdata_sel = wb_pipeline_q_i.pc_plus_4;
      RESULT_SEL_CSR_READ_DATA:   rd_wdata_sel = wb_pipeline_q_i.csr_rdata;
      default:                    rd_wdata_sel = '0;
    endcase
  end

  // a trapped instruction must not retire any write
  assign rd_addr_masked  = trapped ? '0 : wb_pipeline_q_i.rd_addr;
  assign csr_addr_masked = trapped ? '0 : wb_pipeline_q_i.csr_addr;

  // no rd means no data either
  assign rd_wdata_masked = (rd_addr_masked != '0) ? rd_wdata_sel : '0;

  assign wb_rd_addr_o    = rd_addr_masked;
  assign wb_rd_wdata_o   = rd_wdata_masked;
  assign wb_csr_addr_o   = csr_addr_masked;
  assign wb_csr_wdata_o  = wb_pipeline_q_i.csr_wdata;
  assign wb_trap_o       = trap_d;
  assign wb_trap_valid_o = trap_d.valid;

  always_comb begin
    rvfi_o.valid     = wb_pipeline_q_i.valid;
    rvfi_o.intr      = wb_pipeline_q_i.intr;
    rvfi_o.insn      = wb_pipeline_q_i.insn;
    rvfi_o.pc_rdata  = wb_pipeline_q_i.pc;
    rvfi_o.pc_wdata  = wb_pipeline_q_i.next_pc;

    rvfi_o.rs1_addr  = wb_pipeline_q_i.rs1_addr;
    rvfi_o.rs2_addr  = wb_pipeline_q_i.rs2_addr;
    rvfi_o.rs1_rdata = wb_pipeline_q_i.rs1_rdata;
    rvfi_o.rs2_rdata = wb_pipeline_q_i.rs2_rdata;
    rvfi_o.rd_addr   = rd_addr_masked;
    rvfi_o.rd_wdata  = rd_wdata_masked;

    rvfi_o.csr_addr  = csr_addr_masked;
    rvfi_o.csr_rdata = wb_pipeline_q_i.csr_rdata;
    rvfi_o.csr_rmask = wb_csr_rmask_i;
    rvfi_o.csr_wdata = wb_pipeline_q_i.csr_wdata;
    rvfi_o.csr_wmask = wb_csr_wmask_i;

    // effective address comes out of the alu
    rvfi_o.mem_addr  = wb_pipeline_q_i.alu_csr_result;
    rvfi_o.mem_rmask = wb_pipeline_q_i.load_rmask;
    rvfi_o.mem_rdata = wb_pipeline_q_i.load_rdata;
    rvfi_o.mem_wmask = wb_pipeline_q_i.store_wmask;
    rvfi_o.mem_wdata = wb_pipeline_q_i.store_wdata;

    rvfi_o.trap      = trap_d;
  end

endmodule

// File: source/mem_wb_reg.sv
module mem_wb_reg (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                stall_i,
  input  logic                flush_i,
  input  params_pkg::mem_wb_t mem_stage_i,
  output params_pkg::mem_wb_t wb_pipeline_q_o
);
  import params_pkg::*;

  // empty slot: not valid, writes nothing, no trap
  localparam mem_wb_t BUBBLE = '0;

  mem_wb_t wb_pipeline_q;

  // flush has priority over stall so a squashed slot never lingers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_pipeline_q <= BUBBLE;
    end else if (flush_i) begin
      wb_pipeline_q <= BUBBLE;
    end else if (!stall_i) begin
      wb_pipeline_q <= mem_stage_i;
    end
  end

  assign wb_pipeline_q_o = wb_pipeline_q;

endmodule

// File: source/params_pkg.sv
`include "core_defs.svh"

package params_pkg;

  // source of the value written back to rd
  typedef enum logic [1:0] {
    RESULT_SEL_ALU_RESULT      = 2'd0,
    RESULT_SEL_MEM_DATA        = 2'd1,
    RESULT_SEL_NEXT_INSTR_ADDR = 2'd2,
    RESULT_SEL_CSR_READ_DATA   = 2'd3
  } result_sel_t;

  // exception raised somewhere upstream
  typedef struct packed {
    logic                valid;
    logic [`CAUSE_W-1:0] cause;
    logic [`XLEN-1:0]    pc;
  } trap_info_t;

  // record handed from memory stage to writeback
  typedef struct packed {
    logic                   valid;
    logic                   intr;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       next_pc;
    logic [`XLEN-1:0]       insn;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_rdata;
    logic [`XLEN-1:0]       rs2_rdata;
    logic [`REG_ADDR_W-1:0] rd_addr;
    result_sel_t            result_sel;
    // alu result, also the effective address for loads and stores
    logic [`XLEN-1:0]       alu_csr_result;
    logic [`XLEN-1:0]       load_rdata;
    logic [`XLEN-1:0]       pc_plus_4;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`XLEN-1:0]       csr_rdata;
    logic [`XLEN-1:0]       csr_wdata;
    logic [`XLEN/8-1:0]     load_rmask;
    logic [`XLEN/8-1:0]     store_wmask;
    logic [`XLEN-1:0]       store_wdata;
    trap_info_t             carried_trap;
  } mem_wb_t;

  // retirement record for the formal monitor
  typedef struct packed {
    logic                   valid;
    logic                   intr;
    logic [`XLEN-1:0]       insn;
    logic [`XLEN-1:0]       pc_rdata;
    logic [`XLEN-1:0]       pc_wdata;

    // register file
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_rdata;
    logic [`XLEN-1:0]       rs2_rdata;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       rd_wdata;

    // csr access
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`XLEN-1:0]       csr_rdata;
    logic [`XLEN-1:0]       csr_rmask;
    logic [`XLEN-1:0]       csr_wdata;
    logic [`XLEN-1:0]       csr_wmask;

    // data memory
    logic [`XLEN-1:0]       mem_addr;
    logic [`XLEN/8-1:0]     mem_rmask;
    logic [`XLEN-1:0]       mem_rdata;
    logic [`XLEN/8-1:0]     mem_wmask;
    logic [`XLEN-1:0]       mem_wdata;

    trap_info_t             trap;
  } rvfi_t;

endpackage

// File: source/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path width
`define XLEN 32

// integer register file
`define NUM_REGS   32
`define REG_ADDR_W 5

// csr address space and the implemented machine csrs
`define CSR_ADDR_W   12
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

// width of the trap cause carried down the pipe
`define CAUSE_W 4

`endif
